/* verilog/pic_pkg.sv */
package pic_pkg;

    // Interrupt levels and level number width
    localparam int IRQ_W = 8;
    localparam int LEVEL_W = 3;

    // 8086 vector base T7..T3
    localparam int VEC_BASE_W = 5;

    // ICW1 bit positions
    localparam int ICW1_IC4_BIT = 0;
    localparam int ICW1_SNGL_BIT = 1;
    localparam int ICW1_LTIM_BIT = 3;

    // ICW4 bit positions
    localparam int ICW4_AEOI_BIT = 1;

    // OCW3 read register select
    localparam int OCW3_RR_BIT = 1;
    localparam int OCW3_RIS_BIT = 0;

    // Mask and clear value for all levels
    localparam logic [IRQ_W-1:0] ALL_LEVELS = '1;

    // Initialization word sequence
    typedef enum logic [1:0] {
        CMD_READY,
        WRITE_ICW2,
        WRITE_ICW3,
        WRITE_ICW4
    } init_state_e;

    // Two-pulse acknowledge cycle
    typedef enum logic [1:0] {
        CTL_READY,
        ACK1,
        ACK2
    } ack_state_e;

    // OCW2 bits 6:5, only specific EOI is decoded
    typedef enum logic [1:0] {
        OCW2_IGNORE_0 = 2'b00,
        OCW2_IGNORE_1 = 2'b01,
        OCW2_IGNORE_2 = 2'b10,
        SPECIFIC_EOI  = 2'b11
    } ocw2_cmd_e;

    // Lowest set bit wins, empty request gives the top level
    function automatic logic [LEVEL_W-1:0] lowest_level(input logic [IRQ_W-1:0] req);
        logic [LEVEL_W-1:0] lvl;
        lvl = LEVEL_W'(IRQ_W - 1);
        for (int i = IRQ_W - 1; i >= 0; i--) begin
            if (req[i]) begin
                lvl = LEVEL_W'(i);
            end
        end
        return lvl;
    endfunction

    // Level number to one-hot
    function automatic logic [IRQ_W-1:0] level_onehot(input logic [LEVEL_W-1:0] lvl);
        logic [IRQ_W-1:0] mask;
        mask = '0;
        mask[lvl] = 1'b1;
        return mask;
    endfunction

endpackage

/* verilog/pic_cfg_if.sv */
interface pic_cfg_if
    import pic_pkg::*;
();

    // Vector base from ICW2
    logic [VEC_BASE_W-1:0] vector_base;
    // Auto EOI from ICW4
    logic                  aeoi;
    // Sequence finished since last ICW1
    logic                  init_done;
    // One-cycle pulse after an ICW1 write
    logic                  reinit;

    // Driven by the init sequencer
    modport init (
        output vector_base,
        output aeoi,
        output init_done,
        output reinit
    );

    // Read by the operation registers and the acknowledge block
    modport user (
        input vector_base,
        input aeoi,
        input init_done,
        input reinit
    );

endinterface

/* verilog/pic_init_seq.sv */
module pic_init_seq
    import pic_pkg::*;
(
    input  logic       write_ICW_1,
    input  logic       write_ICW_1_rst,
    input  logic [7:0] internal_data_bus,
    input  logic       icw1_wr,
    input  logic       icw2_4_wr,
    output logic       edge_or_level,
    pic_cfg_if.init    cfg
);

    init_state_e state;
    init_state_e state_nxt;
    logic        need_icw4;
    logic        single_mode;
    logic        step_wr;
    logic        last_step;

    // ICW1 restarts the sequence and overrides a same-cycle ICW2..4 write
    assign step_wr = icw2_4_wr && !icw1_wr;

    // Next word expected after an ICW2..4 write
    always_comb begin
        state_nxt = state;
        case (state)
            WRITE_ICW2: begin
                if (!single_mode) begin
                    state_nxt = WRITE_ICW3;
                end else if (need_icw4) begin
                    state_nxt = WRITE_ICW4;
                end else begin
                    state_nxt = CMD_READY;
                end
            end
            WRITE_ICW3: begin
                // Cascade byte taken, value not kept
                state_nxt = need_icw4 ? WRITE_ICW4 : CMD_READY;
            end
            WRITE_ICW4: begin
                state_nxt = CMD_READY;
            end
            default: begin
                // CMD_READY ignores stray ICW2..4 strobes
                state_nxt = CMD_READY;
            end
        endcase
    end

    // Final word of the sequence written
    assign last_step = step_wr && (state != CMD_READY) && (state_nxt == CMD_READY);

    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            state <= CMD_READY;
        end else if (icw1_wr) begin
            state <= WRITE_ICW2;
        end else if (step_wr) begin
            state <= state_nxt;
        end
    end

    // ICW1 fields
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            need_icw4     <= 1'b0;
            single_mode   <= 1'b0;
            edge_or_level <= 1'b0;
        end else if (icw1_wr) begin
            need_icw4     <= internal_data_bus[ICW1_IC4_BIT];
            single_mode   <= internal_data_bus[ICW1_SNGL_BIT];
            edge_or_level <= internal_data_bus[ICW1_LTIM_BIT];
        end
    end

    // ICW2 upper bits and ICW4 AEOI
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            cfg.vector_base <= '0;
            cfg.aeoi        <= 1'b0;
        end else begin
            if (step_wr && state == WRITE_ICW2) begin
                cfg.vector_base <= internal_data_bus[7:8-VEC_BASE_W];
            end
            if (cfg.reinit) begin
                cfg.aeoi <= 1'b0;
            end else if (step_wr && state == WRITE_ICW4) begin
                cfg.aeoi <= internal_data_bus[ICW4_AEOI_BIT];
            end
        end
    end

    // Reinit pulse one cycle after ICW1, done flag on sequence end
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            cfg.reinit    <= 1'b0;
            cfg.init_done <= 1'b0;
        end else begin
            cfg.reinit <= icw1_wr;
            if (last_step) begin
                cfg.init_done <= 1'b1;
            end else if (cfg.reinit) begin
                cfg.init_done <= 1'b0;
            end
        end
    end

endmodule

/* verilog/pic_op_regs.sv */
module pic_op_regs
    import pic_pkg::*;
(
    input  logic             write_ICW_1,
    input  logic             write_ICW_1_rst,
    input  logic [7:0]       internal_data_bus,
    input  logic             ocw1_wr,
    input  logic             ocw2_wr,
    input  logic             ocw3_wr,
    input  logic [IRQ_W-1:0] aeoi_eoi,
    output logic [IRQ_W-1:0] int_mask,
    output logic             en_read_reg,
    output logic             read_reg_isr_or_irr,
    output logic [IRQ_W-1:0] eoi,
    pic_cfg_if.user          cfg
);

    ocw2_cmd_e        ocw2_cmd;
    logic [IRQ_W-1:0] spec_eoi;

    // OCW2 command field
    assign ocw2_cmd = ocw2_cmd_e'(internal_data_bus[6:5]);

    // Specific EOI level from bits 2:0
    always_comb begin
        spec_eoi = '0;
        if (ocw2_wr && ocw2_cmd == SPECIFIC_EOI) begin
            spec_eoi = level_onehot(internal_data_bus[LEVEL_W-1:0]);
        end
    end

    // OCW1 mask, all masked after init
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            int_mask <= ALL_LEVELS;
        end else if (cfg.reinit) begin
            int_mask <= ALL_LEVELS;
        end else if (ocw1_wr) begin
            int_mask <= internal_data_bus;
        end
    end

    // OCW3 read select, IRR by default
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            en_read_reg         <= 1'b1;
            read_reg_isr_or_irr <= 1'b0;
        end else if (cfg.reinit) begin
            en_read_reg         <= 1'b1;
            read_reg_isr_or_irr <= 1'b0;
        end else if (ocw3_wr) begin
            en_read_reg         <= internal_data_bus[OCW3_RR_BIT];
            read_reg_isr_or_irr <= internal_data_bus[OCW3_RIS_BIT];
        end
    end

    // Merged EOI pulse, clears every in-service bit on reinit
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            eoi <= ALL_LEVELS;
        end else if (cfg.reinit) begin
            eoi <= ALL_LEVELS;
        end else begin
            eoi <= spec_eoi | aeoi_eoi;
        end
    end

endmodule

/* verilog/pic_ack_ctrl.sv */
module pic_ack_ctrl
    import pic_pkg::*;
(
    input  logic             write_ICW_1,
    input  logic             write_ICW_1_rst,
    input  logic [IRQ_W-1:0] interrupt,
    input  logic             ack,
    output logic             int_req,
    output logic             latch,
    output logic             freeze,
    output logic [IRQ_W-1:0] clr_ir,
    output logic             out_ctrl_logic_data,
    output logic [7:0]       ctrl_logic_data,
    output logic [IRQ_W-1:0] aeoi_eoi,
    pic_cfg_if.user          cfg
);

    ack_state_e         state;
    logic               ack_q;
    logic               ack_fall;
    logic               ack_rise;
    logic               take_ack;
    logic               end_ack;
    logic [LEVEL_W-1:0] level;

    // ack is active low, sampled once per clock
    assign ack_fall = ack_q && !ack;
    assign ack_rise = !ack_q && ack;

    // First pulse starts service, rise after the second ends it
    assign take_ack = (state == CTL_READY) && ack_fall && int_req;
    assign end_ack  = (state == ACK2) && ack_rise;

    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            ack_q <= 1'b1;
        end else begin
            ack_q <= ack;
        end
    end

    // Acknowledge FSM
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            state <= CTL_READY;
        end else if (cfg.reinit) begin
            state <= CTL_READY;
        end else begin
            case (state)
                CTL_READY: begin
                    if (take_ack) begin
                        state <= ACK1;
                    end
                end
                ACK1: begin
                    if (ack_fall) begin
                        state <= ACK2;
                    end
                end
                ACK2: begin
                    if (ack_rise) begin
                        state <= CTL_READY;
                    end
                end
                default: begin
                    state <= CTL_READY;
                end
            endcase
        end
    end

    // Serviced level, held for the vector and the AEOI pulse
    always_ff @(posedge write_ICW_1) begin
        if (take_ack) begin
            level <= lowest_level(interrupt);
        end
    end

    // Request to the CPU, held until the sequence completes
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            int_req <= 1'b0;
        end else if (cfg.reinit || end_ack) begin
            int_req <= 1'b0;
        end else if (cfg.init_done && state == CTL_READY && interrupt != '0) begin
            int_req <= 1'b1;
        end
    end

    // Latch and clear-request pulse on the first acknowledge
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            latch  <= 1'b0;
            clr_ir <= ALL_LEVELS;
        end else if (cfg.reinit) begin
            latch  <= 1'b0;
            clr_ir <= ALL_LEVELS;
        end else begin
            latch  <= take_ack;
            clr_ir <= take_ack ? interrupt : '0;
        end
    end

    // Freeze request detection while the cycle runs
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            freeze <= 1'b1;
        end else if (cfg.reinit || end_ack) begin
            freeze <= 1'b1;
        end else if (take_ack) begin
            freeze <= 1'b0;
        end
    end

    // Vector on the bus during the second pulse
    assign out_ctrl_logic_data = (state == ACK2);
    assign ctrl_logic_data = out_ctrl_logic_data ? {cfg.vector_base, level} : 8'h00;

    // AEOI clears the serviced level at the end of the cycle
    assign aeoi_eoi = (end_ack && cfg.aeoi) ? level_onehot(level) : '0;

endmodule

/* verilog/pic_control_logic.sv */
module pic_control_logic
    import pic_pkg::*;
(
    input  logic             write_ICW_1,
    input  logic             write_ICW_1_rst,

    // Data and write strobes from the bus interface
    input  logic [7:0]       internal_data_bus,
    input  logic             icw1_wr,
    input  logic             icw2_4_wr,
    input  logic             ocw1_wr,
    input  logic             ocw2_wr,
    input  logic             ocw3_wr,

    // Detected requests and CPU acknowledge
    input  logic [IRQ_W-1:0] interrupt,
    input  logic             ack,

    // Configuration outputs
    output logic             edge_or_level,
    output logic [IRQ_W-1:0] int_mask,
    output logic             en_read_reg,
    output logic             read_reg_isr_or_irr,

    // Vector onto the internal bus
    output logic             out_ctrl_logic_data,
    output logic [7:0]       ctrl_logic_data,

    // Request and in-service handling
    output logic             latch,
    output logic             freeze,
    output logic [IRQ_W-1:0] eoi,
    output logic [IRQ_W-1:0] clr_ir,
    output logic             int_req
);

    logic [IRQ_W-1:0] aeoi_eoi;

    // Init results shared by all blocks
    pic_cfg_if cfg_if ();

    pic_init_seq pic_init_seq_inst (
        .write_ICW_1       (write_ICW_1),
        .write_ICW_1_rst   (write_ICW_1_rst),
        .internal_data_bus (internal_data_bus),
        .icw1_wr           (icw1_wr),
        .icw2_4_wr         (icw2_4_wr),
        .edge_or_level     (edge_or_level),
        .cfg               (cfg_if.init)
    );

    pic_op_regs pic_op_regs_inst (
        .write_ICW_1         (write_ICW_1),
        .write_ICW_1_rst     (write_ICW_1_rst),
        .internal_data_bus   (internal_data_bus),
        .ocw1_wr             (ocw1_wr),
        .ocw2_wr             (ocw2_wr),
        .ocw3_wr             (ocw3_wr),
        .aeoi_eoi            (aeoi_eoi),
        .int_mask            (int_mask),
        .en_read_reg         (en_read_reg),
        .read_reg_isr_or_irr (read_reg_isr_or_irr),
        .eoi                 (eoi),
        .cfg                 (cfg_if.user)
    );

    pic_ack_ctrl pic_ack_ctrl_inst (
        .write_ICW_1         (write_ICW_1),
        .write_ICW_1_rst     (write_ICW_1_rst),
        .interrupt           (interrupt),
        .ack                 (ack),
        .int_req             (int_req),
        .latch               (latch),
        .freeze              (freeze),
        .clr_ir              (clr_ir),
        .out_ctrl_logic_data (out_ctrl_logic_data),
        .ctrl_logic_data     (ctrl_logic_data),
        .aeoi_eoi            (aeoi_eoi),
        .cfg                 (cfg_if.user)
    );

endmodule

/* sim/pic_ack_chk.sv */
module pic_ack_chk
    import pic_pkg::*;
(
    input logic             write_ICW_1,
    input logic             write_ICW_1_rst,
    input logic             ack,
    input logic             latch,
    input logic             freeze,
    input logic [IRQ_W-1:0] clr_ir,
    input logic             out_ctrl_logic_data,
    input ack_state_e       state,
    input logic             reinit
);

    // Latch is a single-cycle strobe
    latch_one_cycle: assert property (
        @(posedge write_ICW_1) disable iff (write_ICW_1_rst)
        latch |=> !latch
    ) else $error("latch held high for more than one cycle");

    // Clear request only with latch, except the all-ones clear after reset or reinit
    clr_ir_with_latch: assert property (
        @(posedge write_ICW_1) disable iff (write_ICW_1_rst)
        (clr_ir != '0) && !$past(reinit) && !$past(write_ICW_1_rst) |-> latch
    ) else $error("clr_ir non-zero without latch");

    // Vector drive only while ack stays low at the previous sample
    vector_while_ack_low: assert property (
        @(posedge write_ICW_1) disable iff (write_ICW_1_rst)
        out_ctrl_logic_data |-> !$past(ack)
    ) else $error("vector driven while ack high");

    // Requests frozen open in the first acknowledge
    no_freeze_in_ack1: assert property (
        @(posedge write_ICW_1) disable iff (write_ICW_1_rst)
        (state == ACK1) |-> !freeze
    ) else $error("freeze high in ACK1");

endmodule

bind pic_ack_ctrl pic_ack_chk pic_ack_chk_inst (
    .write_ICW_1         (write_ICW_1),
    .write_ICW_1_rst     (write_ICW_1_rst),
    .ack                 (ack),
    .latch               (latch),
    .freeze              (freeze),
    .clr_ir              (clr_ir),
    .out_ctrl_logic_data (out_ctrl_logic_data),
    .state               (state),
    .reinit              (cfg.reinit)
);

/* sim/pic_tb.sv */
module pic_tb
    import pic_pkg::*;
();

    // Write strobe select codes
    localparam int SEL_ICW1   = 0;
    localparam int SEL_ICW2_4 = 1;
    localparam int SEL_OCW1   = 2;
    localparam int SEL_OCW2   = 3;
    localparam int SEL_OCW3   = 4;
    localparam int WAIT_LIMIT = 50;

    logic       write_ICW_1 = 1'b0;
    logic       write_ICW_1_rst;
    logic [7:0] internal_data_bus;
    logic       icw1_wr;
    logic       icw2_4_wr;
    logic       ocw1_wr;
    logic       ocw2_wr;
    logic       ocw3_wr;
    logic [7:0] interrupt;
    logic       ack;
    logic       edge_or_level;
    logic [7:0] int_mask;
    logic       en_read_reg;
    logic       read_reg_isr_or_irr;
    logic       out_ctrl_logic_data;
    logic [7:0] ctrl_logic_data;
    logic       latch;
    logic       freeze;
    logic [7:0] eoi;
    logic [7:0] clr_ir;
    logic       int_req;

    // 100 unit clock period
    always #50 write_ICW_1 = ~write_ICW_1;

    pic_control_logic pic_control_logic_inst (
        .write_ICW_1         (write_ICW_1),
        .write_ICW_1_rst     (write_ICW_1_rst),
        .internal_data_bus   (internal_data_bus),
        .icw1_wr             (icw1_wr),
        .icw2_4_wr           (icw2_4_wr),
        .ocw1_wr             (ocw1_wr),
        .ocw2_wr             (ocw2_wr),
        .ocw3_wr             (ocw3_wr),
        .interrupt           (interrupt),
        .ack                 (ack),
        .edge_or_level       (edge_or_level),
        .int_mask            (int_mask),
        .en_read_reg         (en_read_reg),
        .read_reg_isr_or_irr (read_reg_isr_or_irr),
        .out_ctrl_logic_data (out_ctrl_logic_data),
        .ctrl_logic_data     (ctrl_logic_data),
        .latch               (latch),
        .freeze              (freeze),
        .eoi                 (eoi),
        .clr_ir              (clr_ir),
        .int_req             (int_req)
    );

    // Drive point, 10 units past the rising edge
    task automatic tick();
        @(posedge write_ICW_1);
        #10;
    endtask

    task automatic check_eq(input string name, input logic [7:0] actual,
                            input logic [7:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s: got %h expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // One strobe for one cycle with data on the bus
    task automatic write_word(input int sel, input logic [7:0] data);
        internal_data_bus = data;
        icw1_wr   = (sel == SEL_ICW1);
        icw2_4_wr = (sel == SEL_ICW2_4);
        ocw1_wr   = (sel == SEL_OCW1);
        ocw2_wr   = (sel == SEL_OCW2);
        ocw3_wr   = (sel == SEL_OCW3);
        tick();
        icw1_wr   = 1'b0;
        icw2_4_wr = 1'b0;
        ocw1_wr   = 1'b0;
        ocw2_wr   = 1'b0;
        ocw3_wr   = 1'b0;
        internal_data_bus = 8'h00;
    endtask

    task automatic wait_int_req();
        int n;
        n = 0;
        while (int_req !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: int_req did not rise within %0d cycles", WAIT_LIMIT);
                $display("Simulation failed");
                $fatal(1, "int_req timeout");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    // Full two-pulse acknowledge for one request pattern
    task automatic ack_sequence(input logic [7:0] irq, input logic [7:0] exp_vec,
                                input logic [7:0] exp_eoi);
        interrupt = irq;
        wait_int_req();
        check_eq("freeze", 8'(freeze), 8'h01);
        // First pulse latches requests
        ack = 1'b0;
        tick();
        check_eq("latch", 8'(latch), 8'h01);
        check_eq("clr_ir", clr_ir, irq);
        check_eq("freeze", 8'(freeze), 8'h00);
        check_eq("out_ctrl_logic_data", 8'(out_ctrl_logic_data), 8'h00);
        tick();
        check_eq("latch", 8'(latch), 8'h00);
        check_eq("clr_ir", clr_ir, 8'h00);
        ack = 1'b1;
        tick();
        // Second pulse, vector on the bus
        ack = 1'b0;
        tick();
        check_eq("out_ctrl_logic_data", 8'(out_ctrl_logic_data), 8'h01);
        check_eq("ctrl_logic_data", ctrl_logic_data, exp_vec);
        tick();
        check_eq("ctrl_logic_data", ctrl_logic_data, exp_vec);
        ack = 1'b1;
        interrupt = 8'h00;
        tick();
        check_eq("freeze", 8'(freeze), 8'h01);
        check_eq("int_req", 8'(int_req), 8'h00);
        check_eq("out_ctrl_logic_data", 8'(out_ctrl_logic_data), 8'h00);
        check_eq("eoi", eoi, exp_eoi);
        tick();
        check_eq("eoi", eoi, 8'h00);
        check_eq("int_req", 8'(int_req), 8'h00);
    endtask

    task automatic test_reset();
        check_eq("int_mask", int_mask, ALL_LEVELS);
        check_eq("eoi", eoi, ALL_LEVELS);
        check_eq("clr_ir", clr_ir, ALL_LEVELS);
        write_ICW_1_rst = 1'b0;
        tick();
        check_eq("en_read_reg", 8'(en_read_reg), 8'h01);
        check_eq("freeze", 8'(freeze), 8'h01);
        check_eq("int_req", 8'(int_req), 8'h00);
        check_eq("latch", 8'(latch), 8'h00);
        check_eq("out_ctrl_logic_data", 8'(out_ctrl_logic_data), 8'h00);
        check_eq("eoi", eoi, 8'h00);
        check_eq("clr_ir", clr_ir, 8'h00);
    endtask

    task automatic test_single_init();
        // Disturb mask and read select so reinit has work to do
        write_word(SEL_OCW1, 8'h00);
        write_word(SEL_OCW3, 8'h01);
        check_eq("en_read_reg", 8'(en_read_reg), 8'h00);
        write_word(SEL_ICW1, 8'h1B);
        check_eq("edge_or_level", 8'(edge_or_level), 8'h01);
        tick();
        check_eq("int_mask", int_mask, ALL_LEVELS);
        check_eq("en_read_reg", 8'(en_read_reg), 8'h01);
        check_eq("read_reg_isr_or_irr", 8'(read_reg_isr_or_irr), 8'h00);
        check_eq("eoi", eoi, ALL_LEVELS);
        check_eq("clr_ir", clr_ir, ALL_LEVELS);
        check_eq("freeze", 8'(freeze), 8'h01);
        tick();
        check_eq("eoi", eoi, 8'h00);
        check_eq("clr_ir", clr_ir, 8'h00);
        write_word(SEL_ICW2_4, 8'h40);
        write_word(SEL_ICW2_4, 8'h02);
        // Stray write in CMD_READY, base and AEOI must survive
        write_word(SEL_ICW2_4, 8'h00);
        check_eq("edge_or_level", 8'(edge_or_level), 8'h01);
        check_eq("int_mask", int_mask, ALL_LEVELS);
        check_eq("int_req", 8'(int_req), 8'h00);
    endtask

    task automatic test_ocw1_ocw3();
        write_word(SEL_OCW1, 8'h5A);
        check_eq("int_mask", int_mask, 8'h5A);
        write_word(SEL_OCW3, 8'h03);
        check_eq("en_read_reg", 8'(en_read_reg), 8'h01);
        check_eq("read_reg_isr_or_irr", 8'(read_reg_isr_or_irr), 8'h01);
    endtask

    task automatic test_ocw2();
        // Specific EOI on level 4
        write_word(SEL_OCW2, 8'h64);
        check_eq("eoi", eoi, 8'h10);
        tick();
        check_eq("eoi", eoi, 8'h00);
        // Non-specific code is not decoded
        write_word(SEL_OCW2, 8'h20);
        check_eq("eoi", eoi, 8'h00);
        tick();
        check_eq("eoi", eoi, 8'h00);
    endtask

    task automatic test_ack_aeoi();
        // Levels 3 and 5, level 3 served, base 0x40
        ack_sequence(8'h28, 8'h43, 8'h08);
    endtask

    task automatic test_cascade_init();
        write_word(SEL_ICW1, 8'h10);
        check_eq("edge_or_level", 8'(edge_or_level), 8'h00);
        tick();
        check_eq("int_mask", int_mask, ALL_LEVELS);
        tick();
        write_word(SEL_ICW2_4, 8'h88);
        // ICW3 byte taken and dropped
        write_word(SEL_ICW2_4, 8'hFF);
        ack_sequence(8'h01, 8'h88, 8'h00);
    endtask

    initial begin
        write_ICW_1_rst   = 1'b1;
        internal_data_bus = 8'h00;
        icw1_wr   = 1'b0;
        icw2_4_wr = 1'b0;
        ocw1_wr   = 1'b0;
        ocw2_wr   = 1'b0;
        ocw3_wr   = 1'b0;
        interrupt = 8'h00;
        ack       = 1'b1;
        repeat (16) @(posedge write_ICW_1);
        #10;
        test_reset();
        test_single_init();
        test_ocw1_ocw3();
        test_ocw2();
        test_ack_aeoi();
        test_cascade_init();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* filelist.f */
verilog/pic_pkg.sv
verilog/pic_cfg_if.sv
verilog/pic_init_seq.sv
verilog/pic_op_regs.sv
verilog/pic_ack_ctrl.sv
verilog/pic_control_logic.sv
sim/pic_ack_chk.sv
sim/pic_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module pic_tb \
    -Mdir obj_dir \
    -f filelist.f

# A $fatal in the run gives a non-zero exit status
./obj_dir/Vpic_tb
